// File: design/usiBusPkg.sv
// USI register bus definitions
// Word layout and default field widths

package usiBusPkg;

	//------------------------------------------------------------
	// Word width
	//------------------------------------------------------------

	// Default width of address, write and read words
	localparam int lUsiBusWidth = 32;

	//------------------------------------------------------------
	// Command bits in the address word
	//------------------------------------------------------------

	// Write strobe, only set in the command cycle
	localparam int lUsiWrBit = 31;

	// Read strobe, never together with the write bit
	localparam int lUsiRdBit = 30;

	//------------------------------------------------------------
	// Address fields
	//------------------------------------------------------------

	// Block select, sits right above the CSR field
	localparam int lBlockAdrsWidth = 8;

	// CSR offset inside a block, low bits of the word
	localparam int lCsrAdrsWidth = 8;

	// Bits between the block field and the command bits stay zero
	// Idle cycles carry an all-zero address word

endpackage

// File: design/gpioPkg.sv
// GPIO register map
// CSR offsets and reset values

package gpioPkg;

	//------------------------------------------------------------
	// CSR offsets within a block
	//------------------------------------------------------------

	// Output data, drives R when alternate mode is off
	localparam int unsigned lGpioOutOfs = 'h00;

	// Direction, 1 = pin is an output
	localparam int unsigned lGpioDirOfs = 'h04;

	// Per-pin alternate-mode select
	localparam int unsigned lGpioAltOfs = 'h08;

	// Synchronized pin inputs, read only
	localparam int unsigned lGpioInOfs = 'h0C;

	// Any other offset is unmapped
	// Writes dropped, reads return zero

	//------------------------------------------------------------
	// Reset values
	//------------------------------------------------------------

	// Every writable register and the pin register
	localparam int unsigned lGpioRstVal = 0;

endpackage

// File: design/UsiHostBridge.sv
// USI host bridge
// Host strobes to bus words, fixed-latency read return
module UsiHostBridge
	import usiBusPkg::*;
#(
	parameter int pUsiBusWidth    = lUsiBusWidth,
	parameter int pBlockAdrsWidth = lBlockAdrsWidth,
	parameter int pCsrAdrsWidth   = lCsrAdrsWidth
)(
	input  logic                                     iSCLK,
	input  logic                                     rstN,
	// Host side
	input  logic                                     hostWrEn,
	input  logic                                     hostRdEn,
	input  logic [pBlockAdrsWidth+pCsrAdrsWidth-1:0] hostAdrs,
	input  logic [pUsiBusWidth-1:0]                  hostWd,
	output logic [pUsiBusWidth-1:0]                  hostRd,
	output logic                                     hostRdValid,
	// Bus side
	output logic [pUsiBusWidth-1:0]                  usiAdrs,
	output logic [pUsiBusWidth-1:0]                  usiWd,
	input  logic [pUsiBusWidth-1:0]                  usiRdA,
	input  logic [pUsiBusWidth-1:0]                  usiRdB
);

	localparam int lHostAdrsWidth = pBlockAdrsWidth + pCsrAdrsWidth;

	// Next address word
	logic [pUsiBusWidth-1:0] adrsNext;
	// Read in flight, bit 0 = on bus, bit 1 = CSR answered
	logic [1:0]              rdPend;

	//------------------------------------------------------------
	// Command word build
	//------------------------------------------------------------

	always_comb
	begin
		adrsNext = '0;
		// Idle cycles keep the word at zero
		if (hostWrEn || hostRdEn)
		begin
			adrsNext[lHostAdrsWidth-1:0] = hostAdrs;
			adrsNext[lUsiWrBit]          = hostWrEn;
			adrsNext[lUsiRdBit]          = hostRdEn;
		end
	end

	// Address word, edge 1
	always_ff @(posedge iSCLK)
	begin
		if (!rstN)
			usiAdrs <= '0;
		else
			usiAdrs <= adrsNext;
	end

	// Write data follows the address word
	always_ff @(posedge iSCLK)
	begin
		usiWd <= hostWd;
	end

	//------------------------------------------------------------
	// Read return
	//------------------------------------------------------------

	// Two-stage pending shift
	always_ff @(posedge iSCLK)
	begin
		if (!rstN)
		begin
			rdPend      <= '0;
			hostRdValid <= 1'b0;
		end
		else
		begin
			rdPend      <= {rdPend[0], hostRdEn};
			// Valid lands on edge 3
			hostRdValid <= rdPend[1];
		end
	end

	// Unaddressed blocks return zero, so plain OR merges
	always_ff @(posedge iSCLK)
	begin
		hostRd <= usiRdA | usiRdB;
	end

endmodule

// File: design/GpioCsr.sv
// GPIO CSR bank
// Decode, register storage, input sync, read-back
module GpioCsr
	import usiBusPkg::*, gpioPkg::*;
#(
	parameter int                   pBlockAdrsWidth = lBlockAdrsWidth,
	parameter [pBlockAdrsWidth-1:0] pAdrsMap        = 'h01,
	parameter int                   pUsiBusWidth    = lUsiBusWidth,
	parameter int                   pCsrAdrsWidth   = lCsrAdrsWidth,
	parameter int                   pGpioWidth      = 16
)(
	input  logic                    iSCLK,
	input  logic                    rstN,
	// Bus write side
	input  logic [pUsiBusWidth-1:0] usiWd,
	input  logic [pUsiBusWidth-1:0] usiAdrs,
	// Bus read side
	output logic [pUsiBusWidth-1:0] usiRd,
	// Register outputs
	output logic [pGpioWidth-1:0]   gpioOutCtrl,
	output logic [pGpioWidth-1:0]   gpioDir,
	output logic [pGpioWidth-1:0]   gpioAltMode,
	// Raw pin inputs
	input  logic [pGpioWidth-1:0]   iGpioIn
);

	// Address fields
	logic [pBlockAdrsWidth-1:0] blockField;
	logic [pCsrAdrsWidth-1:0]   csrOfs;
	// Decoded commands for this block
	logic                       blockHit;
	logic                       wrHit;
	logic                       rdHit;
	// Write payload, pin-width slice
	logic [pGpioWidth-1:0]      wrData;
	// Input synchronizer
	logic [pGpioWidth-1:0]      inMeta;
	logic [pGpioWidth-1:0]      inReg;
	// Selected register for read
	logic [pGpioWidth-1:0]      rdSel;

	//------------------------------------------------------------
	// Address decode
	//------------------------------------------------------------

	assign blockField = usiAdrs[pCsrAdrsWidth +: pBlockAdrsWidth];
	assign csrOfs     = usiAdrs[pCsrAdrsWidth-1:0];
	assign blockHit   = (blockField == pAdrsMap);
	// Command bits only live for one cycle
	assign wrHit      = blockHit & usiAdrs[lUsiWrBit];
	assign rdHit      = blockHit & usiAdrs[lUsiRdBit];
	// Upper data bits ignored
	assign wrData     = usiWd[pGpioWidth-1:0];

	//------------------------------------------------------------
	// Writable registers
	//------------------------------------------------------------

	always_ff @(posedge iSCLK)
	begin
		if (!rstN)
		begin
			gpioOutCtrl <= pGpioWidth'(lGpioRstVal);
			gpioDir     <= pGpioWidth'(lGpioRstVal);
			gpioAltMode <= pGpioWidth'(lGpioRstVal);
		end
		else if (wrHit)
		begin
			// Input register and unmapped offsets drop the write
			case (csrOfs)
				pCsrAdrsWidth'(lGpioOutOfs): gpioOutCtrl <= wrData;
				pCsrAdrsWidth'(lGpioDirOfs): gpioDir     <= wrData;
				pCsrAdrsWidth'(lGpioAltOfs): gpioAltMode <= wrData;
				default:
				begin
				end
			endcase
		end
	end

	//------------------------------------------------------------
	// Input synchronizer
	//------------------------------------------------------------

	// Two flops, current 2 edges after a pin change
	always_ff @(posedge iSCLK)
	begin
		if (!rstN)
		begin
			inMeta <= '0;
			inReg  <= '0;
		end
		else
		begin
			inMeta <= iGpioIn;
			inReg  <= inMeta;
		end
	end

	//------------------------------------------------------------
	// Read-back
	//------------------------------------------------------------

	always_comb
	begin
		case (csrOfs)
			pCsrAdrsWidth'(lGpioOutOfs): rdSel = gpioOutCtrl;
			pCsrAdrsWidth'(lGpioDirOfs): rdSel = gpioDir;
			pCsrAdrsWidth'(lGpioAltOfs): rdSel = gpioAltMode;
			pCsrAdrsWidth'(lGpioInOfs):  rdSel = inReg;
			default:                     rdSel = '0;
		endcase
	end

	// Zero unless a read to this block was just decoded
	always_ff @(posedge iSCLK)
	begin
		if (!rstN)
			usiRd <= '0;
		else
			usiRd <= rdHit ? pUsiBusWidth'(rdSel) : '0;
	end

endmodule

// File: design/GpioBlock.sv
// GPIO block
// CSR bank and per-pin output select
module GpioBlock
	import usiBusPkg::*, gpioPkg::*;
#(
	parameter int                   pBlockAdrsWidth = lBlockAdrsWidth,
	parameter [pBlockAdrsWidth-1:0] pAdrsMap        = 'h01,
	parameter int                   pUsiBusWidth    = lUsiBusWidth,
	parameter int                   pCsrAdrsWidth   = lCsrAdrsWidth,
	parameter int                   pGpioWidth      = 16
)(
	input  logic                    iSCLK,
	input  logic                    rstN,
	// Pin side
	output logic [pGpioWidth-1:0]   gpioR,
	output logic [pGpioWidth-1:0]   gpioDir,
	input  logic [pGpioWidth-1:0]   iGpioAltMode,
	input  logic [pGpioWidth-1:0]   iGpioIn,
	// Global alternate override
	input  logic                    iSmsMode,
	// Bus side
	input  logic [pUsiBusWidth-1:0] usiWd,
	input  logic [pUsiBusWidth-1:0] usiAdrs,
	output logic [pUsiBusWidth-1:0] usiRd
);

	// CSR register outputs
	logic [pGpioWidth-1:0] gpioOutCtrl;
	logic [pGpioWidth-1:0] gpioAltMode;

	//------------------------------------------------------------
	// CSR bank
	//------------------------------------------------------------

	// Direction goes straight to the pins
	GpioCsr #(
		.pBlockAdrsWidth(pBlockAdrsWidth),
		.pAdrsMap       (pAdrsMap),
		.pUsiBusWidth   (pUsiBusWidth),
		.pCsrAdrsWidth  (pCsrAdrsWidth),
		.pGpioWidth     (pGpioWidth)
	) csr (
		.iSCLK      (iSCLK),
		.rstN       (rstN),
		.usiWd      (usiWd),
		.usiAdrs    (usiAdrs),
		.usiRd      (usiRd),
		.gpioOutCtrl(gpioOutCtrl),
		.gpioDir    (gpioDir),
		.gpioAltMode(gpioAltMode),
		.iGpioIn    (iGpioIn)
	);

	//------------------------------------------------------------
	// Pin output register
	//------------------------------------------------------------

	// Alternate bit when override or per-pin mode set
	for (genvar pinX = 0; pinX < pGpioWidth; pinX++)
	begin : genPin
		always_ff @(posedge iSCLK)
		begin
			if (!rstN)
				gpioR[pinX] <= 1'(lGpioRstVal);
			else if (iSmsMode || gpioAltMode[pinX])
				gpioR[pinX] <= iGpioAltMode[pinX];
			else
				gpioR[pinX] <= gpioOutCtrl[pinX];
		end
	end

endmodule

// File: design/GpioSubsystem.sv
// GPIO subsystem top
// Host bridge with two GPIO blocks
module GpioSubsystem
	import usiBusPkg::*;
#(
	parameter int pUsiBusWidth    = lUsiBusWidth,
	parameter int pBlockAdrsWidth = lBlockAdrsWidth,
	parameter int pCsrAdrsWidth   = lCsrAdrsWidth
)(
	input  logic                                     iSCLK,
	input  logic                                     rstN,
	// Host port
	input  logic                                     hostWrEn,
	input  logic                                     hostRdEn,
	input  logic [pBlockAdrsWidth+pCsrAdrsWidth-1:0] hostAdrs,
	input  logic [pUsiBusWidth-1:0]                  hostWd,
	output logic [pUsiBusWidth-1:0]                  hostRd,
	output logic                                     hostRdValid,
	// Block A pins
	output logic [15:0]                              gpioAR,
	output logic [15:0]                              gpioADir,
	input  logic [15:0]                              gpioAAltMode,
	input  logic [15:0]                              gpioAIn,
	// Block B pins
	output logic [7:0]                               gpioBR,
	output logic [7:0]                               gpioBDir,
	input  logic [7:0]                               gpioBAltMode,
	input  logic [7:0]                               gpioBIn,
	// Shared override
	input  logic                                     iSmsMode
);

	// Block addresses and pin counts
	localparam logic [pBlockAdrsWidth-1:0] lGpioAMap   = 'h01;
	localparam logic [pBlockAdrsWidth-1:0] lGpioBMap   = 'h02;
	localparam int                         lGpioAWidth = 16;
	localparam int                         lGpioBWidth = 8;

	// Internal bus
	logic [pUsiBusWidth-1:0] usiAdrs;
	logic [pUsiBusWidth-1:0] usiWd;
	logic [pUsiBusWidth-1:0] usiRdA;
	logic [pUsiBusWidth-1:0] usiRdB;

	//------------------------------------------------------------
	// Host bridge
	//------------------------------------------------------------

	UsiHostBridge #(
		.pUsiBusWidth   (pUsiBusWidth),
		.pBlockAdrsWidth(pBlockAdrsWidth),
		.pCsrAdrsWidth  (pCsrAdrsWidth)
	) bridge (
		.iSCLK(iSCLK), .rstN(rstN),
		.hostWrEn(hostWrEn), .hostRdEn(hostRdEn), .hostAdrs(hostAdrs),
		.hostWd(hostWd), .hostRd(hostRd), .hostRdValid(hostRdValid),
		.usiAdrs(usiAdrs), .usiWd(usiWd), .usiRdA(usiRdA), .usiRdB(usiRdB)
	);

	//------------------------------------------------------------
	// GPIO blocks
	//------------------------------------------------------------

	// Block A, 16 pins
	GpioBlock #(
		.pBlockAdrsWidth(pBlockAdrsWidth), .pAdrsMap(lGpioAMap),
		.pUsiBusWidth(pUsiBusWidth), .pCsrAdrsWidth(pCsrAdrsWidth),
		.pGpioWidth(lGpioAWidth)
	) gpioA (
		.iSCLK(iSCLK), .rstN(rstN), .gpioR(gpioAR), .gpioDir(gpioADir),
		.iGpioAltMode(gpioAAltMode), .iGpioIn(gpioAIn), .iSmsMode(iSmsMode),
		.usiWd(usiWd), .usiAdrs(usiAdrs), .usiRd(usiRdA)
	);

	// Block B, 8 pins
	GpioBlock #(
		.pBlockAdrsWidth(pBlockAdrsWidth), .pAdrsMap(lGpioBMap),
		.pUsiBusWidth(pUsiBusWidth), .pCsrAdrsWidth(pCsrAdrsWidth),
		.pGpioWidth(lGpioBWidth)
	) gpioB (
		.iSCLK(iSCLK), .rstN(rstN), .gpioR(gpioBR), .gpioDir(gpioBDir),
		.iGpioAltMode(gpioBAltMode), .iGpioIn(gpioBIn), .iSmsMode(iSmsMode),
		.usiWd(usiWd), .usiAdrs(usiAdrs), .usiRd(usiRdB)
	);

endmodule

// File: dv/GpioSubsystemTb.sv
// GPIO subsystem testbench
// Table-driven stimulus with reference model
module GpioSubsystemTb
	import usiBusPkg::*, gpioPkg::*;
();

	timeunit 1ns;
	timeprecision 1ps;

	//------------------------------------------------------------
	// Table layout and constants
	//------------------------------------------------------------

	localparam logic [1:0] opWr  = 2'd0;
	localparam logic [1:0] opRd  = 2'd1;
	localparam logic [1:0] opPin = 2'd2;

	localparam logic [7:0] blkA    = 8'h01;
	localparam logic [7:0] blkB    = 8'h02;
	// Nothing decodes this one
	localparam logic [7:0] blkNone = 8'h03;

	localparam logic [7:0] ofsOut = 8'(lGpioOutOfs);
	localparam logic [7:0] ofsDir = 8'(lGpioDirOfs);
	localparam logic [7:0] ofsAlt = 8'(lGpioAltOfs);
	localparam logic [7:0] ofsIn  = 8'(lGpioInOfs);

	// One stimulus step and what must follow it
	typedef struct packed {
		logic [1:0]  op;
		logic [7:0]  blk;
		logic [7:0]  ofs;
		logic [31:0] data;
		logic [15:0] altA;
		logic [7:0]  altB;
		logic [15:0] pinA;
		logic [7:0]  pinB;
		logic        sms;
		logic [31:0] expRd;
		logic [15:0] expRA;
		logic [7:0]  expRB;
		logic [15:0] expDirA;
		logic [7:0]  expDirB;
	} entryT;

	// DUT ports
	logic        iSCLK;
	logic        rstN;
	logic        hostWrEn;
	logic        hostRdEn;
	logic [15:0] hostAdrs;
	logic [31:0] hostWd;
	logic [31:0] hostRd;
	logic        hostRdValid;
	logic [15:0] gpioAR;
	logic [15:0] gpioADir;
	logic [15:0] gpioAAltMode;
	logic [15:0] gpioAIn;
	logic [7:0]  gpioBR;
	logic [7:0]  gpioBDir;
	logic [7:0]  gpioBAltMode;
	logic [7:0]  gpioBIn;
	logic        iSmsMode;

	// Stimulus table and bookkeeping
	entryT       stimQ[$];
	logic        tableReady = 1'b0;
	integer      seed = 32'h9cb7_8020;
	int          errCnt = 0;
	int          checkCnt = 0;

	// Reference model state, index 0 = block A
	logic [15:0] shOut [2];
	logic [15:0] shDir [2];
	logic [15:0] shAlt [2];
	logic [15:0] curAltA;
	logic [7:0]  curAltB;
	logic [15:0] curPinA;
	logic [7:0]  curPinB;
	logic        curSms;

	GpioSubsystem dut_i (
		.iSCLK(iSCLK), .rstN(rstN),
		.hostWrEn(hostWrEn), .hostRdEn(hostRdEn), .hostAdrs(hostAdrs),
		.hostWd(hostWd), .hostRd(hostRd), .hostRdValid(hostRdValid),
		.gpioAR(gpioAR), .gpioADir(gpioADir),
		.gpioAAltMode(gpioAAltMode), .gpioAIn(gpioAIn),
		.gpioBR(gpioBR), .gpioBDir(gpioBDir),
		.gpioBAltMode(gpioBAltMode), .gpioBIn(gpioBIn),
		.iSmsMode(iSmsMode)
	);

	initial
	begin
		iSCLK = 1'b0;
		forever #5 iSCLK = ~iSCLK;
	end

	//------------------------------------------------------------
	// Reference model
	//------------------------------------------------------------

	function automatic logic [31:0] randWord();
		randWord = $random(seed);
	endfunction

	// -1 for an unmapped block
	function automatic int blkIndex(input logic [7:0] blk);
		if (blk == blkA)
			return 0;
		if (blk == blkB)
			return 1;
		return -1;
	endfunction

	function automatic logic [15:0] pinMask(input int idx);
		return (idx == 0) ? 16'hFFFF : 16'h00FF;
	endfunction

	// Override or alt-mode bit picks the alternate input
	function automatic logic [15:0] expectPins(input logic [15:0] outReg,
		input logic [15:0] altReg, input logic [15:0] altIn, input logic sms);
		logic [15:0] sel;
		sel = sms ? 16'hFFFF : altReg;
		return (altIn & sel) | (outReg & ~sel);
	endfunction

	function automatic logic [31:0] modelRead(input int idx, input logic [7:0] ofs);
		if (idx < 0)
			return 32'h0;
		case (ofs)
			ofsOut: return {16'h0, shOut[idx]};
			ofsDir: return {16'h0, shDir[idx]};
			ofsAlt: return {16'h0, shAlt[idx]};
			ofsIn:  return (idx == 0) ? {16'h0, curPinA} : {24'h0, curPinB};
			default: return 32'h0;
		endcase
	endfunction

	// Model one step and append it with its expected values
	task automatic addEntry(input logic [1:0] op, input logic [7:0] blk,
		input logic [7:0] ofs, input logic [31:0] data);
		entryT       e;
		int          idx;
		logic [15:0] pins;
		idx    = blkIndex(blk);
		e.op   = op;
		e.blk  = blk;
		e.ofs  = ofs;
		e.data = data;
		e.altA = curAltA;
		e.altB = curAltB;
		e.pinA = curPinA;
		e.pinB = curPinB;
		e.sms  = curSms;
		e.expRd = 32'h0;
		// Input register and unknown offsets keep their state
		if (op == opWr && idx >= 0)
		begin
			case (ofs)
				ofsOut: shOut[idx] = data[15:0] & pinMask(idx);
				ofsDir: shDir[idx] = data[15:0] & pinMask(idx);
				ofsAlt: shAlt[idx] = data[15:0] & pinMask(idx);
				default:
				begin
				end
			endcase
		end
		if (op == opRd)
			e.expRd = modelRead(idx, ofs);
		pins      = expectPins(shOut[0], shAlt[0], curAltA, curSms);
		e.expRA   = pins;
		pins      = expectPins(shOut[1], shAlt[1], {8'h00, curAltB}, curSms);
		e.expRB   = pins[7:0];
		e.expDirA = shDir[0];
		e.expDirB = shDir[1][7:0];
		stimQ.push_back(e);
	endtask

	task automatic setPins(input logic [15:0] altA, input logic [7:0] altB,
		input logic [15:0] pinA, input logic [7:0] pinB, input logic sms);
		curAltA = altA;
		curAltB = altB;
		curPinA = pinA;
		curPinB = pinB;
		curSms  = sms;
		addEntry(opPin, 8'h00, 8'h00, 32'h0);
	endtask

	//------------------------------------------------------------
	// Table contents
	//------------------------------------------------------------

	task automatic buildTable();
		logic [31:0] w;
		for (int i = 0; i < 2; i++)
		begin
			shOut[i] = 16'h0;
			shDir[i] = 16'h0;
			shAlt[i] = 16'h0;
		end
		curAltA = 16'h0;
		curAltB = 8'h0;
		curPinA = 16'h0;
		curPinB = 8'h0;
		curSms  = 1'b0;
		// Every CSR reads zero out of reset
		for (int b = 1; b <= 2; b++)
			for (int o = 0; o < 16; o += 4)
				addEntry(opRd, 8'(b), 8'(o), 32'h0);
		// Random write then read-back, upper bits must drop
		for (int b = 1; b <= 2; b++)
			for (int o = 0; o < 12; o += 4)
			begin
				addEntry(opWr, 8'(b), 8'(o), randWord());
				addEntry(opRd, 8'(b), 8'(o), 32'h0);
			end
		// Mixed per-pin select, override low
		for (int n = 0; n < 3; n++)
		begin
			w = randWord();
			setPins(w[15:0], w[23:16], curPinA, curPinB, 1'b0);
			addEntry(opWr, blkA, ofsAlt, randWord());
			addEntry(opWr, blkB, ofsAlt, randWord());
			addEntry(opWr, blkA, ofsOut, randWord());
			addEntry(opWr, blkB, ofsOut, randWord());
		end
		// Global override, CSR writes must not reach R
		w = randWord();
		setPins(w[15:0], w[31:24], curPinA, curPinB, 1'b1);
		addEntry(opWr, blkA, ofsOut, randWord());
		addEntry(opWr, blkB, ofsAlt, randWord());
		setPins(curAltA, curAltB, curPinA, curPinB, 1'b0);
		// Synchronized input sampling
		for (int n = 0; n < 4; n++)
		begin
			w = randWord();
			setPins(curAltA, curAltB, w[15:0], w[23:16], 1'b0);
			addEntry(opRd, blkA, ofsIn, 32'h0);
			addEntry(opRd, blkB, ofsIn, 32'h0);
		end
		// Isolation between blocks and the unmapped address
		addEntry(opWr, blkA, ofsDir, randWord());
		addEntry(opRd, blkB, ofsDir, 32'h0);
		addEntry(opWr, blkB, ofsOut, randWord());
		addEntry(opRd, blkA, ofsOut, 32'h0);
		addEntry(opWr, blkNone, ofsOut, randWord());
		addEntry(opWr, blkNone, ofsDir, randWord());
		for (int o = 0; o < 16; o += 4)
			addEntry(opRd, blkNone, 8'(o), 32'h0);
		addEntry(opWr, blkA, ofsIn, randWord());
		addEntry(opRd, blkA, 8'h10, 32'h0);
		for (int b = 1; b <= 2; b++)
			for (int o = 0; o < 16; o += 4)
				addEntry(opRd, 8'(b), 8'(o), 32'h0);
	endtask

	//------------------------------------------------------------
	// Drivers and checks
	//------------------------------------------------------------

	task automatic checkVal(input string name, input logic [31:0] exp, input logic [31:0] got);
		checkCnt++;
		assert (got === exp)
		else
		begin
			errCnt++;
			$display("Error: %s expected 0x%h got 0x%h", name, exp, got);
		end
	endtask

	task automatic checkPins(input entryT e);
		checkVal("gpioAR", {16'h0, e.expRA}, {16'h0, gpioAR});
		checkVal("gpioBR", {24'h0, e.expRB}, {24'h0, gpioBR});
		checkVal("gpioADir", {16'h0, e.expDirA}, {16'h0, gpioADir});
		checkVal("gpioBDir", {24'h0, e.expDirB}, {24'h0, gpioBDir});
	endtask

	// R must be current 3 edges after the strobe is sampled
	// Sampling edge counts as edge 1
	task automatic doWrite(input entryT e);
		@(posedge iSCLK);
		hostWrEn <= 1'b1;
		hostAdrs <= {e.blk, e.ofs};
		hostWd   <= e.data;
		@(posedge iSCLK);
		hostWrEn <= 1'b0;
		repeat (2) @(posedge iSCLK);
		@(negedge iSCLK);
	endtask

	task automatic doRead(input entryT e);
		int lat;
		@(posedge iSCLK);
		hostRdEn <= 1'b1;
		hostAdrs <= {e.blk, e.ofs};
		@(posedge iSCLK);
		hostRdEn <= 1'b0;
		// Edge that sampled the strobe is edge 1
		lat = 1;
		@(negedge iSCLK);
		while (!hostRdValid && lat < 10)
		begin
			@(negedge iSCLK);
			lat++;
		end
		checkCnt++;
		assert (hostRdValid)
		else
		begin
			errCnt++;
			$display("Read of block %h offset %h never returned hostRdValid", e.blk, e.ofs);
		end
		if (hostRdValid)
		begin
			checkVal("hostRdValid latency", 32'd3, 32'(lat));
			checkVal("hostRd", e.expRd, hostRd);
		end
	endtask

	// Three edges cover the input sync and pin register
	task automatic doPins(input entryT e);
		@(posedge iSCLK);
		gpioAAltMode <= e.altA;
		gpioBAltMode <= e.altB;
		gpioAIn      <= e.pinA;
		gpioBIn      <= e.pinB;
		iSmsMode     <= e.sms;
		repeat (3) @(posedge iSCLK);
		@(negedge iSCLK);
	endtask

	//------------------------------------------------------------
	// Main sequence
	//------------------------------------------------------------

	initial
	begin
		entryT e;
		rstN         = 1'b0;
		hostWrEn     = 1'b0;
		hostRdEn     = 1'b0;
		hostAdrs     = 16'h0;
		hostWd       = 32'h0;
		gpioAAltMode = 16'h0;
		gpioAIn      = 16'h0;
		gpioBAltMode = 8'h0;
		gpioBIn      = 8'h0;
		iSmsMode     = 1'b0;
		buildTable();
		tableReady = 1'b1;
		repeat (5) @(posedge iSCLK);
		rstN <= 1'b1;
		@(negedge iSCLK);
		// Outputs straight out of reset
		checkVal("gpioAR", 32'h0, {16'h0, gpioAR});
		checkVal("gpioADir", 32'h0, {16'h0, gpioADir});
		checkVal("gpioBR", 32'h0, {24'h0, gpioBR});
		checkVal("gpioBDir", 32'h0, {24'h0, gpioBDir});
		checkVal("hostRdValid", 32'h0, {31'h0, hostRdValid});
		for (int i = 0; i < stimQ.size(); i++)
		begin
			e = stimQ[i];
			case (e.op)
				opWr:    doWrite(e);
				opRd:    doRead(e);
				default: doPins(e);
			endcase
			checkPins(e);
		end
		$display("Checks: %0d, errors: %0d", checkCnt, errCnt);
		if (errCnt == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// Watchdog, 10 cycles per table entry plus margin
	initial
	begin
		int limitCycles;
		wait (tableReady);
		limitCycles = stimQ.size() * 10 + 50;
		repeat (limitCycles) @(posedge iSCLK);
		$display("Timeout: the table did not finish within %0d cycles", limitCycles);
		$display("Checks: %0d, errors: %0d", checkCnt, errCnt);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: GpioSubsystem.f
design/usiBusPkg.sv
design/gpioPkg.sv
design/UsiHostBridge.sv
design/GpioCsr.sv
design/GpioBlock.sv
design/GpioSubsystem.sv
dv/GpioSubsystemTb.sv

// File: run.sh
#!/bin/sh
# Build and run the GPIO subsystem testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
	-f GpioSubsystem.f \
	--top-module GpioSubsystemTb \
	-o GpioSubsystemSim

./obj_dir/GpioSubsystemSim > sim.log 2>&1
cat sim.log

if grep -q "SIMULATION FAILED" sim.log; then
	exit 1
fi

if ! grep -q "SIMULATION PASSED" sim.log; then
	echo "No pass message found in sim.log"
	exit 1
fi

exit 0
